// File: logic/tetrisPkg.sv
`default_nettype none

package tetrisPkg;

    // Fixed board geometry
    // Row 0 is the top row
    localparam int boardRows = 20;
    localparam int boardCols = 10;
    localparam int rowBits   = 5;   // Row index 0..19

    // Piece shapes
    // Code 7 is left free and draws nothing
    typedef enum logic [2:0] {
        pieceLine     = 3'd0,
        pieceSquare   = 3'd1,
        pieceL        = 3'd2,
        pieceReverseL = 3'd3,
        pieceS        = 3'd4,
        pieceZ        = 3'd5,
        pieceT        = 3'd6
    } pieceKind;

    // Life cycle of one falling piece
    typedef enum logic [1:0] {
        stIdle    = 2'd0,   // Waiting for spawn
        stFalling = 2'd1,   // Piece live, moves on tick
        stLock    = 2'd2,   // Piece merges into stack
        stOver    = 2'd3    // Spawn collided, held until reset
    } dropState;

endpackage

`default_nettype wire

// File: logic/pieceDrop.sv
`timescale 1ns/1ns
`default_nettype none

module pieceDrop import tetrisPkg::*; (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   load,
    input  logic                                   step,
    input  pieceKind                               kind,
    output logic [0:boardRows-1][0:boardCols-1]    activeMask,
    output logic [0:boardRows-1][0:boardCols-1]    probeMask,
    output logic                                   atFloor
);

    logic [rowBits-1:0] rowQ;       // Top row of the active piece
    pieceKind           kindQ;      // Kind latched at spawn
    logic [rowBits:0]   rowBottom;  // Lowest occupied row

    // Number of rows a kind occupies
    function automatic logic [2:0] pieceHeight(input pieceKind k);
        case (k)
            pieceLine:     return 3'd4;
            pieceSquare:   return 3'd2;
            pieceL:        return 3'd3;
            pieceReverseL: return 3'd3;
            pieceS:        return 3'd2;
            pieceZ:        return 3'd2;
            pieceT:        return 3'd2;
            default:       return 3'd1;
        endcase
    endfunction

    // Cell pattern of kind k with its top row at r
    function automatic logic [0:boardRows-1][0:boardCols-1] drawPiece(
        input pieceKind         k,
        input logic [rowBits:0] r
    );
        logic [0:boardRows-1][0:boardCols-1] m;
        m = '0;
        if (r + {3'b000, pieceHeight(k)} <= (rowBits + 1)'(boardRows)) begin  // Stay on board
            case (k)
                pieceLine: begin
                    m[r][4]     = 1'b1;
                    m[r + 1][4] = 1'b1;
                    m[r + 2][4] = 1'b1;
                    m[r + 3][4] = 1'b1;
                end
                pieceSquare: begin
                    m[r][4]     = 1'b1;
                    m[r][5]     = 1'b1;
                    m[r + 1][4] = 1'b1;
                    m[r + 1][5] = 1'b1;
                end
                pieceL: begin
                    m[r][4]     = 1'b1;
                    m[r + 1][4] = 1'b1;
                    m[r + 2][4] = 1'b1;
                    m[r + 2][5] = 1'b1;  // Foot to the right
                end
                pieceReverseL: begin
                    m[r][5]     = 1'b1;
                    m[r + 1][5] = 1'b1;
                    m[r + 2][5] = 1'b1;
                    m[r + 2][4] = 1'b1;  // Foot to the left
                end
                pieceS: begin
                    m[r][5]     = 1'b1;
                    m[r][6]     = 1'b1;
                    m[r + 1][4] = 1'b1;
                    m[r + 1][5] = 1'b1;
                end
                pieceZ: begin
                    m[r][4]     = 1'b1;
                    m[r][5]     = 1'b1;
                    m[r + 1][5] = 1'b1;
                    m[r + 1][6] = 1'b1;
                end
                pieceT: begin
                    m[r][4]     = 1'b1;  // Nose points up
                    m[r + 1][3] = 1'b1;
                    m[r + 1][4] = 1'b1;
                    m[r + 1][5] = 1'b1;
                end
                default: begin
                    m = '0;
                end
            endcase
        end
        return m;
    endfunction

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rowQ  <= '0;
            kindQ <= pieceLine;
        end else if (load) begin
            rowQ  <= '0;          // Spawn at the top
            kindQ <= kind;
        end else if (step) begin
            rowQ  <= rowQ + 1'b1;
        end
    end

    assign activeMask = drawPiece(kindQ, {1'b0, rowQ});
    assign probeMask  = drawPiece(kindQ, {1'b0, rowQ} + 1'b1);  // One row lower

    assign rowBottom = {1'b0, rowQ} + {3'b000, pieceHeight(kindQ)} - 1'b1;
    assign atFloor   = (rowBottom >= (rowBits + 1)'(boardRows - 1));

endmodule

`default_nettype wire

// File: logic/stackStore.sv
`timescale 1ns/1ns
`default_nettype none

module stackStore import tetrisPkg::*; (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   lock,
    input  logic [0:boardRows-1][0:boardCols-1]    activeMask,
    output logic [0:boardRows-1][0:boardCols-1]    stack,
    output logic [7:0]                             linesCleared
);

    logic [0:boardRows-1][0:boardCols-1] merged;    // Stack with piece dropped in
    logic [0:boardRows-1][0:boardCols-1] compacted; // Full rows squeezed out
    logic [rowBits-1:0]                  removedRows;
    int                                  dstRow;

    // Walk upward from the floor, copy every row that is not full
    // to the next free slot from the bottom; anything left above stays empty
    always_comb begin
        merged      = stack | activeMask;
        compacted   = '0;
        removedRows = '0;
        dstRow      = boardRows - 1;
        for (int srcRow = boardRows - 1; srcRow >= 0; srcRow--) begin
            if (&merged[srcRow]) begin
                removedRows = removedRows + 1'b1;  // Full row dropped
            end else begin
                compacted[dstRow] = merged[srcRow];
                dstRow            = dstRow - 1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            stack        <= '0;
            linesCleared <= '0;
        end else if (lock) begin
            stack        <= compacted;
            linesCleared <= linesCleared + {3'b000, removedRows};  // Wraps at 256
        end
    end

endmodule

`default_nettype wire

// File: logic/dropControl.sv
`timescale 1ns/1ns
`default_nettype none

module dropControl import tetrisPkg::*; (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   spawn,
    input  logic                                   tick,
    input  logic                                   atFloor,
    input  logic [0:boardRows-1][0:boardCols-1]    activeMask,
    input  logic [0:boardRows-1][0:boardCols-1]    probeMask,
    input  logic [0:boardRows-1][0:boardCols-1]    stack,
    output logic                                   load,
    output logic                                   step,
    output logic                                   lock,
    output logic                                   landed,
    output logic                                   busy,
    output logic                                   gameOver,
    output logic [0:boardRows-1][0:boardCols-1]    board
);

    dropState state, stateNext;
    logic     justSpawned;   // First stFalling cycle of a piece
    logic     spawnHit;      // Fresh piece sits on settled cells
    logic     probeHit;      // Next row down is taken
    logic     blocked;
    logic     falling;

    assign spawnHit = |(activeMask & stack);
    assign probeHit = |(probeMask & stack);
    assign falling  = (state == stFalling);
    assign blocked  = atFloor || probeHit;

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (spawn) stateNext = stFalling;
            end
            stFalling: begin
                if (justSpawned && spawnHit) stateNext = stOver;
                else if (tick && blocked) stateNext = stLock;
            end
            stLock:  stateNext = stIdle;   // Merge takes one cycle
            default: stateNext = stOver;   // Only reset leaves stOver
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state       <= stIdle;
            justSpawned <= 1'b0;
        end else begin
            state       <= stateNext;
            justSpawned <= load;
        end
    end

    assign load     = (state == stIdle) && spawn;
    assign step     = falling && tick && !blocked && !(justSpawned && spawnHit);
    assign lock     = (state == stLock);
    assign landed   = (state == stLock);
    assign busy     = falling || (state == stLock);
    assign gameOver = (state == stOver);

    // Live piece only shown while it is on the board
    assign board = busy ? (stack | activeMask) : stack;

endmodule

`default_nettype wire

// File: logic/tetrisBoard.sv
`timescale 1ns/1ns
`default_nettype none

module tetrisBoard import tetrisPkg::*; (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   spawn,
    input  pieceKind                               pieceSel,
    input  logic                                   tick,
    output logic [0:boardRows-1][0:boardCols-1]    board,
    output logic                                   landed,
    output logic                                   busy,
    output logic                                   gameOver,
    output logic [7:0]                             linesCleared
);

    logic                                load;
    logic                                step;
    logic                                lock;
    logic                                atFloor;
    logic [0:boardRows-1][0:boardCols-1] activeMask;
    logic [0:boardRows-1][0:boardCols-1] probeMask;
    logic [0:boardRows-1][0:boardCols-1] stack;

    pieceDrop piece (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .step       (step),
        .kind       (pieceSel),
        .activeMask (activeMask),
        .probeMask  (probeMask),
        .atFloor    (atFloor)
    );

    stackStore store (
        .clk          (clk),
        .rst          (rst),
        .lock         (lock),
        .activeMask   (activeMask),   // Piece shape at its resting row
        .stack        (stack),
        .linesCleared (linesCleared)
    );

    dropControl ctrl (
        .clk        (clk),
        .rst        (rst),
        .spawn      (spawn),
        .tick       (tick),
        .atFloor    (atFloor),
        .activeMask (activeMask),
        .probeMask  (probeMask),
        .stack      (stack),
        .load       (load),
        .step       (step),
        .lock       (lock),
        .landed     (landed),
        .busy       (busy),
        .gameOver   (gameOver),
        .board      (board)
    );

endmodule

`default_nettype wire

// File: dv/tetrisBoard_chk.sv
`timescale 1ns/1ns
`default_nettype none

module tetrisBoardChk (
    input logic clk,
    input logic rst,
    input logic landed,
    input logic busy,
    input logic gameOver,
    input logic load,
    input logic lock
);

    // Lock state lasts a single cycle, then the piece is gone
    landedOnePulse: assert property (
        @(posedge clk) disable iff (rst) landed |=> (!landed && !busy)
    ) else $error("landed was not a single cycle followed by busy low");

    // Only reset clears a lost game
    gameOverSticky: assert property (
        @(posedge clk) disable iff (rst) gameOver |=> gameOver
    ) else $error("gameOver fell without a reset");

    loadLockExclusive: assert property (
        @(posedge clk) disable iff (rst) !(load && lock)
    ) else $error("load and lock were high in the same cycle");

endmodule

bind tetrisBoard tetrisBoardChk chk (
    .clk      (clk),
    .rst      (rst),
    .landed   (landed),
    .busy     (busy),
    .gameOver (gameOver),
    .load     (load),
    .lock     (lock)
);

`default_nettype wire

// File: dv/tetrisBoardTb.sv
`timescale 1ns/1ns
`default_nettype none

module tetrisBoardTb import tetrisPkg::*; ();

    localparam int    clkHalf     = 4;
    localparam int    driveDelay  = 1;    // Inputs change after the edge
    localparam int    busyTimeout = 16;
    localparam int    randSeed    = 98095;
    localparam int    boardBits   = boardRows * boardCols;
    localparam string goldenPath  = "dv/dropGolden.txt";

    logic                                clk;
    logic                                rst;
    logic                                spawn;
    logic                                tick;
    pieceKind                            pieceSel;
    logic [0:boardRows-1][0:boardCols-1] board;
    logic                                landed;
    logic                                busy;
    logic                                gameOver;
    logic [7:0]                          linesCleared;

    tetrisBoard uut (
        .clk          (clk),
        .rst          (rst),
        .spawn        (spawn),
        .pieceSel     (pieceSel),
        .tick         (tick),
        .board        (board),
        .landed       (landed),
        .busy         (busy),
        .gameOver     (gameOver),
        .linesCleared (linesCleared)
    );

    always #clkHalf clk = ~clk;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #driveDelay;
    endtask

    task automatic idleGap();
        int gap;
        gap = $urandom % 4;   // 0 to 3 quiet cycles
        repeat (gap) nextCycle();
    endtask

    task automatic issueSpawn(input int code);
        pieceSel = pieceKind'(code[2:0]);
        spawn    = 1'b1;
        nextCycle();
        spawn    = 1'b0;
        nextCycle();          // Overlap verdict shows one cycle after load
    endtask

    task automatic issueTicks(input int count);
        for (int k = 0; k < count; k++) begin
            if (k > 0) idleGap();
            tick = 1'b1;
            nextCycle();
            tick = 1'b0;
        end
    endtask

    task automatic checkResponse(
        input int                   idx,
        input int                   expLanded,
        input int                   expLines,
        input int                   expOver,
        input logic                 expBusy,
        input logic [boardBits-1:0] expBoard
    );
        logic                 gotLanded;
        logic [boardBits-1:0] gotBoard;
        int                   cycles;
        gotLanded = landed;
        assert (gotLanded == expLanded[0]) else
            stopRun($sformatf("Error: cmd%0d landed expected %0d actual %0b",
                              idx, expLanded, gotLanded));
        cycles = 0;
        while (gotLanded && busy && cycles < busyTimeout) begin
            nextCycle();
            cycles++;
        end
        assert (!(gotLanded && busy)) else
            stopRun($sformatf("Command %0d: busy never fell after landed", idx));
        gotBoard = board;
        assert (busy == expBusy) else
            stopRun($sformatf("Error: cmd%0d busy expected %0b actual %0b",
                              idx, expBusy, busy));
        assert (linesCleared == expLines[7:0]) else
            stopRun($sformatf("Error: cmd%0d linesCleared expected %0d actual %0d",
                              idx, expLines, linesCleared));
        assert (gameOver == expOver[0]) else
            stopRun($sformatf("Error: cmd%0d gameOver expected %0d actual %0b",
                              idx, expOver, gameOver));
        assert (gotBoard == expBoard) else
            stopRun($sformatf("Error: cmd%0d board expected %h actual %h",
                              idx, expBoard, gotBoard));
    endtask

    initial begin
        int                   fd;
        int                   fields;
        int                   cmdCount;
        int                   arg;
        int                   expLanded;
        int                   expLines;
        int                   expOver;
        logic                 pieceLive;
        string                lineText;
        string                cmd;
        logic [boardBits-1:0] expBoard;

        clk       = 1'b0;
        rst       = 1'b1;
        spawn     = 1'b0;
        tick      = 1'b0;
        pieceSel  = pieceLine;
        cmdCount  = 0;
        pieceLive = 1'b0;
        void'($urandom(randSeed));

        repeat (2) @(posedge clk);
        #driveDelay;
        rst = 1'b0;

        fd = $fopen(goldenPath, "r");
        assert (fd != 0) else stopRun("Could not open the golden file dv/dropGolden.txt");

        while (!$feof(fd)) begin
            lineText = "";
            void'($fgets(lineText, fd));
            if (lineText.len() < 2 || lineText[0] == "#") continue;  // Blank or comment
            fields = $sscanf(lineText, "%s %d %d %d %d %h",
                             cmd, arg, expLanded, expLines, expOver, expBoard);
            assert (fields == 6) else
                stopRun($sformatf("Golden line %0d could not be parsed", cmdCount));
            idleGap();
            if (cmd == "S") begin
                issueSpawn(arg);
                pieceLive = (expOver == 0);  // Live unless the game is lost
            end else if (cmd == "T") begin
                issueTicks(arg);
                pieceLive = pieceLive && (expLanded == 0) && (expOver == 0);
            end else begin
                stopRun($sformatf("Unknown command %s in the golden file", cmd));
            end
            checkResponse(cmdCount, expLanded, expLines, expOver, pieceLive, expBoard);
            cmdCount++;
        end
        $fclose(fd);

        if (cmdCount > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stopRun("The golden file held no commands");
        end
    end

endmodule

`default_nettype wire

// File: dv/dropGolden.txt
# Each line holds command, argument, landed, linesCleared, gameOver and board
# For S the argument is the piece code and for T the number of ticks
# Board is 50 hex digits with row 0 first and column 0 as each row's top bit
# Pieces only reach columns 3 to 6 so rows never fill and linesCleared stays 0
S 0 0 0 0 08020080200000000000000000000000000000000000000000
T 1 0 0 0 00020080200800000000000000000000000000000000000000
T 16 1 0 0 00000000000000000000000000000000000000000802008020
T 2 0 0 0 00000000000000000000000000000000000000000802008020
S 1 0 0 0 0C030000000000000000000000000000000000000802008020
S 2 0 0 0 0C030000000000000000000000000000000000000802008020
T 15 1 0 0 000000000000000000000000000000000000C0300802008020
S 2 0 0 0 080200C00000000000000000000000000000C0300802008020
T 12 1 0 0 00000000000000000000000000000020080300C0300802008020
S 3 0 0 0 040100C00000000000000000000020080300C0300802008020
T 9 1 0 0 00000000000000000000040100C020080300C0300802008020
S 4 0 0 0 06030000000000000000040100C020080300C0300802008020
T 7 1 0 0 00000000000000006030040100C020080300C0300802008020
S 5 0 0 0 0C018000000000006030040100C020080300C0300802008020
T 5 1 0 0 00000000000C01806030040100C020080300C0300802008020
S 6 0 0 0 08070000000C01806030040100C020080300C0300802008020
T 3 1 0 0 00000080700C01806030040100C020080300C0300802008020
S 0 0 0 1 00000080700C01806030040100C020080300C0300802008020
T 2 0 0 1 00000080700C01806030040100C020080300C0300802008020
S 1 0 0 1 00000080700C01806030040100C020080300C0300802008020

// File: src.f
logic/tetrisPkg.sv
logic/pieceDrop.sv
logic/stackStore.sv
logic/dropControl.sv
logic/tetrisBoard.sv
dv/tetrisBoard_chk.sv
dv/tetrisBoardTb.sv
